/* all.f */
+incdir+include
rtl/radar_seq_pkg.sv
rtl/radar_chirp_pkg.sv
rtl/param_sync.sv
rtl/pulse_sequencer.sv
rtl/chirp_strobe_gen.sv
rtl/radar_pulse_ctrl_top.sv
test/radar_checker.sv
test/tb_radar_pulse_ctrl.sv

/* include/radar_config.svh */
`ifndef RADAR_CONFIG_SVH
`define RADAR_CONFIG_SVH

//////////////////////////////
// field widths
//////////////////////////////

// every control word from the register map
`define RADAR_WORD_W 32

// pulse interval count, integer word over fraction word
`define RADAR_PRF_W 64

// width of the short fixed-phase counters
`define RADAR_PHASE_CNT_W 4

//////////////////////////////
// reset values
//////////////////////////////

// timing words
`define RADAR_PRF_INT_INIT 32'h0000_0000
`define RADAR_PRF_FRAC_INIT 32'h927c_0000
`define RADAR_ADC_TIME_INIT 32'h0000_00c8

// chirp generator parameter fields
`define RADAR_CH_CTRL_INIT 32'h0000_0020
`define RADAR_CH_OFFSET_INIT 32'h0000_0600
`define RADAR_CH_COEF_INIT 32'h0000_0001
`define RADAR_CH_CMAX_INIT 32'h0000_0fff

//////////////////////////////
// fixed phase lengths
//////////////////////////////

// cycles spent in process and overhead
`define RADAR_PROCESS_CYCLES 2
`define RADAR_OVERHEAD_CYCLES 2

// depth of the resync chain, fixed by param_sync
`define RADAR_SYNC_STAGES 3

`endif

/* rtl/chirp_strobe_gen.sv */
`timescale 1ns/1ps

// chirp and adc controls, one cycle behind the sequencer state
module chirp_strobe_gen (
  input  logic                      aclk,
  input  logic                      aresetn,
  input  radar_seq_pkg::seq_state_t state,
  input  logic                      chirp_active,
  output logic                      chirp_init,
  output logic                      chirp_enable,
  output logic                      adc_enable
);

  // decoded state
  logic in_chirp;
  logic in_collect;

  assign in_chirp   = (state == radar_seq_pkg::seq_chirp);
  assign in_collect = (state == radar_seq_pkg::seq_collect);

  //////////////////////////////
  // chirp controls
  //////////////////////////////

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      chirp_enable <= 1'b0;
      chirp_init   <= 1'b0;
    end else begin
      // level for the whole chirp state
      chirp_enable <= in_chirp;
      // first chirp cycle only
      // enable already high blocks a second pulse
      // active high means the generator is still busy
      chirp_init <= in_chirp && !chirp_active && !chirp_enable;
    end
  end

  //////////////////////////////
  // adc control
  //////////////////////////////

  // samples kept during the chirp and the collect tail
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      adc_enable <= 1'b0;
    end else begin
      adc_enable <= in_chirp || in_collect;
    end
  end

endmodule

/* rtl/param_sync.sv */
`timescale 1ns/1ps

// resync for a group of control words from the register map
// two capture flops, then a hold stage that only moves on change
module param_sync #(
  parameter int width = 32,
  parameter logic [width-1:0] reset_value = '0
) (
  input  logic             aclk,
  input  logic             aresetn,
  input  logic [width-1:0] din,
  output logic [width-1:0] dout
);

  // capture stages
  logic [width-1:0] stage_1;
  logic [width-1:0] stage_2;
  // held output stage
  logic [width-1:0] stage_3;

  //////////////////////////////
  // register chain
  //////////////////////////////

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      // whole chain starts at the config defaults
      stage_1 <= reset_value;
      stage_2 <= reset_value;
      stage_3 <= reset_value;
    end else begin
      stage_1 <= din;
      stage_2 <= stage_1;
      // load only on a new value
      if (stage_3 != stage_2) begin
        stage_3 <= stage_2;
      end
    end
  end

  assign dout = stage_3;

endmodule

/* rtl/pulse_sequencer.sv */
`timescale 1ns/1ps

`include "radar_config.svh"

// pulse state machine
// idle -> active -> chirp -> collect -> process -> overhead -> idle
module pulse_sequencer (
  input  logic                       aclk,
  input  logic                       aresetn,
  input  radar_seq_pkg::prf_timing_t timing,
  input  logic                       chirp_ready,
  input  logic                       chirp_done,
  output radar_seq_pkg::seq_state_t  state
);

  // fixed phase lengths
  localparam logic [`RADAR_PHASE_CNT_W-1:0] process_len = `RADAR_PROCESS_CYCLES;
  localparam logic [`RADAR_PHASE_CNT_W-1:0] overhead_len = `RADAR_OVERHEAD_CYCLES;

  radar_seq_pkg::seq_state_t next_state;

  // full interval, integer word on top
  logic [`RADAR_PRF_W-1:0] interval_len;

  // down-counters
  logic [`RADAR_PRF_W-1:0]       interval_cnt;
  logic [`RADAR_WORD_W-1:0]      collect_cnt;
  logic [`RADAR_PHASE_CNT_W-1:0] process_cnt;
  logic [`RADAR_PHASE_CNT_W-1:0] overhead_cnt;

  assign interval_len = {timing.prf_int, timing.prf_frac};

  //////////////////////////////
  // phase counters
  //////////////////////////////

  // all counters reload only in idle
  // so new timing lands on the next pulse

  // interval, runs out in active
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      interval_cnt <= '0;
    end else if (state == radar_seq_pkg::seq_active && interval_cnt != '0) begin
      interval_cnt <= interval_cnt - 1'b1;
    end else if (state == radar_seq_pkg::seq_idle) begin
      interval_cnt <= interval_len;
    end
  end

  // adc collect length
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      collect_cnt <= '0;
    end else if (state == radar_seq_pkg::seq_collect && collect_cnt != '0) begin
      collect_cnt <= collect_cnt - 1'b1;
    end else if (state == radar_seq_pkg::seq_idle) begin
      collect_cnt <= timing.adc_time;
    end
  end

  // process phase
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      process_cnt <= '0;
    end else if (state == radar_seq_pkg::seq_process && process_cnt != '0) begin
      process_cnt <= process_cnt - 1'b1;
    end else if (state == radar_seq_pkg::seq_idle) begin
      process_cnt <= process_len;
    end
  end

  // overhead phase
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      overhead_cnt <= '0;
    end else if (state == radar_seq_pkg::seq_overhead && overhead_cnt != '0) begin
      overhead_cnt <= overhead_cnt - 1'b1;
    end else if (state == radar_seq_pkg::seq_idle) begin
      overhead_cnt <= overhead_len;
    end
  end

  //////////////////////////////
  // next state
  //////////////////////////////

  always_comb begin
    next_state = state;
    case (state)
      radar_seq_pkg::seq_idle: begin
        // wait for the generator
        if (chirp_ready) begin
          next_state = radar_seq_pkg::seq_active;
        end
      end
      radar_seq_pkg::seq_active: begin
        // interval spent and generator still ready
        // N+1 cycles here at the least
        if (chirp_ready && interval_cnt == '0) begin
          next_state = radar_seq_pkg::seq_chirp;
        end
      end
      radar_seq_pkg::seq_chirp: begin
        // held until the generator reports the end
        if (chirp_done) begin
          next_state = radar_seq_pkg::seq_collect;
        end
      end
      radar_seq_pkg::seq_collect: begin
        // last collect cycle, adc_time of at least 1 assumed
        if (collect_cnt == 1) begin
          next_state = radar_seq_pkg::seq_process;
        end
      end
      radar_seq_pkg::seq_process: begin
        // transmit path skipped, straight to overhead
        if (process_cnt == 1) begin
          next_state = radar_seq_pkg::seq_overhead;
        end
      end
      radar_seq_pkg::seq_overhead: begin
        if (overhead_cnt == 1) begin
          next_state = radar_seq_pkg::seq_idle;
        end
      end
      default: begin
        // unused codes recover to idle
        next_state = radar_seq_pkg::seq_idle;
      end
    endcase
  end

  //////////////////////////////
  // state register
  //////////////////////////////

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= radar_seq_pkg::seq_idle;
    end else begin
      state <= next_state;
    end
  end

endmodule

/* rtl/radar_chirp_pkg.sv */
`include "radar_config.svh"

package radar_chirp_pkg;

  //////////////////////////////
  // chirp waveform parameters
  //////////////////////////////

  // forwarded to the chirp generator unchanged
  // field order high to low as the register map packs it
  typedef struct packed {
    // generator mode bits
    logic [`RADAR_WORD_W-1:0] ctrl_word;
    // start frequency offset
    logic [`RADAR_WORD_W-1:0] freq_offset;
    // phase increment slope
    logic [`RADAR_WORD_W-1:0] tuning_coef;
    // ramp length in generator ticks
    logic [`RADAR_WORD_W-1:0] counter_max;
  } chirp_params_t;

endpackage

/* rtl/radar_pulse_ctrl_top.sv */
`timescale 1ns/1ps

`include "radar_config.svh"

// radar pulse controller
// resyncs the register map words and sequences each pulse
module radar_pulse_ctrl_top (
  input  logic                          aclk,
  input  logic                          aresetn,
  input  radar_seq_pkg::prf_timing_t    timing_in,
  input  radar_chirp_pkg::chirp_params_t chirp_params_in,
  output radar_chirp_pkg::chirp_params_t chirp_params_out,
  // high while the generator can take a chirp
  input  logic                          chirp_ready,
  // high while chirping
  input  logic                          chirp_active,
  // one pulse at chirp end
  input  logic                          chirp_done,
  output logic                          chirp_init,
  output logic                          chirp_enable,
  output logic                          adc_enable
);

  // timing after the resync chain
  radar_seq_pkg::prf_timing_t timing_sync;

  radar_seq_pkg::seq_state_t state;

  //////////////////////////////
  // input resync
  //////////////////////////////

  // timing words
  param_sync #(
    .width       ($bits(radar_seq_pkg::prf_timing_t)),
    .reset_value ({`RADAR_PRF_INT_INIT, `RADAR_PRF_FRAC_INIT, `RADAR_ADC_TIME_INIT})
  ) u_timing_sync (
    .aclk    (aclk),
    .aresetn (aresetn),
    .din     (timing_in),
    .dout    (timing_sync)
  );

  // chirp parameters go straight out
  param_sync #(
    .width       ($bits(radar_chirp_pkg::chirp_params_t)),
    .reset_value ({`RADAR_CH_CTRL_INIT, `RADAR_CH_OFFSET_INIT,
                   `RADAR_CH_COEF_INIT, `RADAR_CH_CMAX_INIT})
  ) u_chirp_sync (
    .aclk    (aclk),
    .aresetn (aresetn),
    .din     (chirp_params_in),
    .dout    (chirp_params_out)
  );

  //////////////////////////////
  // sequencing
  //////////////////////////////

  pulse_sequencer u_sequencer (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .timing      (timing_sync),
    .chirp_ready (chirp_ready),
    .chirp_done  (chirp_done),
    .state       (state)
  );

  // registered strobes from state
  chirp_strobe_gen u_strobes (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .state        (state),
    .chirp_active (chirp_active),
    .chirp_init   (chirp_init),
    .chirp_enable (chirp_enable),
    .adc_enable   (adc_enable)
  );

endmodule

/* rtl/radar_seq_pkg.sv */
`include "radar_config.svh"

package radar_seq_pkg;

  //////////////////////////////
  // sequencer states
  //////////////////////////////

  // codes 101 and 110 left unused
  typedef enum logic [2:0] {
    seq_idle     = 3'b000,
    seq_active   = 3'b001,
    // chirp out, adc samples start
    seq_chirp    = 3'b010,
    // keep collecting adc samples
    seq_collect  = 3'b011,
    seq_process  = 3'b100,
    // clean up before next pulse
    seq_overhead = 3'b111
  } seq_state_t;

  //////////////////////////////
  // pulse timing control
  //////////////////////////////

  // interval count is {prf_int, prf_frac}
  typedef struct packed {
    logic [`RADAR_WORD_W-1:0] prf_int;
    logic [`RADAR_WORD_W-1:0] prf_frac;
    // adc collect length in cycles
    logic [`RADAR_WORD_W-1:0] adc_time;
  } prf_timing_t;

endpackage

/* test/radar_checker.sv */
`timescale 1ns/1ps

`include "radar_config.svh"

// watches the DUT ports, predicts the strobe edges, counts mismatches
module radar_checker (
  input  logic                           aclk,
  input  logic                           aresetn,
  input  radar_chirp_pkg::chirp_params_t chirp_params_in,
  input  radar_chirp_pkg::chirp_params_t chirp_params_out,
  input  logic                           chirp_ready,
  input  logic                           chirp_done,
  input  logic                           chirp_init,
  input  logic                           chirp_enable,
  input  logic                           adc_enable,
  // N and M of the pulse now running
  input  logic [`RADAR_PRF_W-1:0]        exp_n,
  input  logic [`RADAR_WORD_W-1:0]       exp_m,
  output int                             error_count
);

  localparam radar_chirp_pkg::chirp_params_t params_reset = {`RADAR_CH_CTRL_INIT,
    `RADAR_CH_OFFSET_INIT, `RADAR_CH_COEF_INIT, `RADAR_CH_CMAX_INIT};

  int errors = 0;
  // posedges so far, negedges seen out of reset
  longint edge_cnt = 0;
  longint run_cnt = 0;
  // edge numbers for the last done, the last ready low and the due edges
  longint done_edge;
  longint low_edge;
  longint enable_due;
  longint adc_due;
  longint init_due;
  logic [`RADAR_WORD_W-1:0] gap_m;
  logic done_seen = 1'b0;
  logic enable_armed = 1'b0;
  logic adc_armed = 1'b0;
  logic prev_init = 1'b0;
  logic prev_enable = 1'b0;
  logic prev_adc = 1'b0;
  // input word at the last three negedges, newest first
  radar_chirp_pkg::chirp_params_t hist [3];

  assign error_count = errors;

  task automatic flag_error(input string msg);
    errors = errors + 1;
    $display("[ERROR] %0t: %s", $time, msg);
  endtask

  always @(posedge aclk) begin
    edge_cnt <= edge_cnt + 1;
  end

  //////////////////////////////
  // strobe timing
  //////////////////////////////

  task automatic check_pulses;
    if (chirp_init && prev_init) flag_error("chirp_init high for more than one cycle");
    if (chirp_enable && !prev_enable && !chirp_init) flag_error("chirp_enable rose alone");
    if (chirp_init && !prev_init) begin
      if (!chirp_enable || prev_enable) flag_error("chirp_init apart from chirp_enable rise");
      if (!chirp_ready) flag_error("chirp_init while chirp_ready low");
      if (done_seen) begin
        // M+N+7 after done, or N+3 after the last stalled edge
        init_due = done_edge + longint'(gap_m) + longint'(exp_n) + 7;
        if (low_edge + longint'(exp_n) + 3 > init_due) init_due = low_edge + longint'(exp_n) + 3;
        if (edge_cnt != init_due) begin
          flag_error($sformatf("chirp_init at edge %0d, expected %0d", edge_cnt, init_due));
        end
      end
      done_seen = 1'b0;
    end
    // both rise on the same edge, every chirp
    if ((adc_enable && !prev_adc) != (chirp_enable && !prev_enable)) begin
      flag_error("adc_enable and chirp_enable did not rise together");
    end
    if (prev_enable && !chirp_enable) begin
      if (!enable_armed || edge_cnt != enable_due) begin
        flag_error($sformatf("chirp_enable fell at edge %0d, expected %0d", edge_cnt, enable_due));
      end
      enable_armed = 1'b0;
      adc_due = edge_cnt + longint'(gap_m);
      adc_armed = 1'b1;
    end
    if (prev_adc && !adc_enable) begin
      if (!adc_armed || edge_cnt != adc_due) begin
        flag_error($sformatf("adc_enable fell at edge %0d, expected %0d", edge_cnt, adc_due));
      end
      adc_armed = 1'b0;
    end
    // done seen here is sampled on the next edge
    if (chirp_done) begin
      done_edge = edge_cnt + 1;
      gap_m = exp_m;
      low_edge = 0;
      done_seen = 1'b1;
      enable_due = edge_cnt + 2;
      enable_armed = 1'b1;
    end else if (!chirp_ready && done_seen) begin
      low_edge = edge_cnt + 1;
    end
  endtask

  //////////////////////////////
  // sampling at the falling edge
  //////////////////////////////

  always @(negedge aclk) begin
    // in reset and the first edge after it
    if (edge_cnt >= 1 && run_cnt <= 1) begin
      if (chirp_init !== 1'b0 || chirp_enable !== 1'b0 || adc_enable !== 1'b0) begin
        flag_error("strobes not low around reset");
      end
      if (chirp_params_out !== params_reset) flag_error("chirp_params_out not at reset value");
    end
    // three edges through the resync chain
    if (run_cnt >= 3 && hist[0] === hist[1] && hist[1] === hist[2]) begin
      if (chirp_params_out !== hist[2]) flag_error("chirp_params_out differs from held input");
    end
    if (run_cnt >= 1) check_pulses();
    hist[2] = hist[1];
    hist[1] = hist[0];
    hist[0] = chirp_params_in;
    if (aresetn) run_cnt = run_cnt + 1;
    prev_init = chirp_init;
    prev_enable = chirp_enable;
    prev_adc = adc_enable;
  end

endmodule

/* test/stim_input.txt */
// prf_int prf_frac adc_time ctrl_word freq_offset tuning_coef counter_max (hex)
// then chirp length K and ready gap G (decimal), one pulse per line
00000000 0000000a 00000004 00000021 00000640 00000002 00000800 5 0
00000000 00000003 00000001 00000022 00000700 00000003 00000400 3 2
00000000 00000014 00000008 00000023 00000780 00000001 00000fff 8 20
00000000 00000000 00000002 00000024 00000800 00000004 00000200 2 0
00000000 00000006 0000000c 00000025 00000900 00000005 00000100 6 15
00000000 00000001 00000003 00000026 00000a00 00000006 00000300 4 6
00000000 00000020 00000005 00000027 00000b00 00000007 00000600 10 0
00000000 00000002 00000001 00000028 00000c00 00000008 00000080 2 30
00000000 00000009 00000010 00000029 00000d00 00000009 00000700 7 1
00000000 00000004 00000006 0000002a 00000e00 0000000a 00000900 3 9

/* test/tb_radar_pulse_ctrl.sv */
`timescale 1ns/1ps

`include "radar_config.svh"

module tb_radar_pulse_ctrl;

  localparam int max_vectors = 32;

  logic aclk;
  logic aresetn;
  radar_seq_pkg::prf_timing_t timing_in;
  radar_chirp_pkg::chirp_params_t chirp_params_in;
  radar_chirp_pkg::chirp_params_t chirp_params_out;
  logic chirp_ready;
  logic chirp_active;
  logic chirp_done;
  logic chirp_init;
  logic chirp_enable;
  logic adc_enable;
  logic [`RADAR_PRF_W-1:0] exp_n;
  logic [`RADAR_WORD_W-1:0] exp_m;
  int mismatch_count;
  int other_errors = 0;
  longint cycle_cnt = 0;
  longint cycle_limit = 0;
  logic limit_set = 1'b0;
  integer seed = 8383;
  int n_vec;
  int v;
  bit ok;
  // vectors from the file
  radar_seq_pkg::prf_timing_t vec_timing [max_vectors];
  radar_chirp_pkg::chirp_params_t vec_params [max_vectors];
  int vec_k [max_vectors];
  int vec_g [max_vectors];

  radar_pulse_ctrl_top uut (.aclk(aclk), .aresetn(aresetn), .timing_in(timing_in),
    .chirp_params_in(chirp_params_in), .chirp_params_out(chirp_params_out),
    .chirp_ready(chirp_ready), .chirp_active(chirp_active), .chirp_done(chirp_done),
    .chirp_init(chirp_init), .chirp_enable(chirp_enable), .adc_enable(adc_enable));

  radar_checker chk (.aclk(aclk), .aresetn(aresetn), .chirp_params_in(chirp_params_in),
    .chirp_params_out(chirp_params_out), .chirp_ready(chirp_ready), .chirp_done(chirp_done),
    .chirp_init(chirp_init), .chirp_enable(chirp_enable), .adc_enable(adc_enable),
    .exp_n(exp_n), .exp_m(exp_m), .error_count(mismatch_count));

  initial begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk;
  end

  task automatic load_vectors(output bit good);
    int fd;
    int cnt;
    int k;
    int g;
    string line;
    logic [31:0] w [7];
    good = 1'b0;
    n_vec = 0;
    fd = $fopen("test/stim_input.txt", "r");
    if (fd == 0) begin
      $display("error: cannot open test/stim_input.txt");
      other_errors = other_errors + 1;
    end else begin
      while ($fgets(line, fd) != 0) begin
        // comment lines give no fields
        cnt = $sscanf(line, "%h %h %h %h %h %h %h %d %d",
                      w[0], w[1], w[2], w[3], w[4], w[5], w[6], k, g);
        if (cnt == 9 && n_vec < max_vectors) begin
          vec_timing[n_vec] = {w[0], w[1], w[2]};
          vec_params[n_vec] = {w[3], w[4], w[5], w[6]};
          vec_k[n_vec] = k;
          vec_g[n_vec] = g;
          cycle_limit = cycle_limit + {w[0], w[1]} + w[2] + k + g + 40;
          n_vec = n_vec + 1;
        end else if (cnt > 0) begin
          $display("error: unreadable line in test/stim_input.txt");
          other_errors = other_errors + 1;
        end
      end
      $fclose(fd);
      if (n_vec == 0) begin
        $display("error: no test vectors in test/stim_input.txt");
        other_errors = other_errors + 1;
      end else begin
        good = 1'b1;
        limit_set = 1'b1;
      end
    end
  endtask

  task automatic apply_vector(input int idx);
    timing_in = vec_timing[idx];
    chirp_params_in = vec_params[idx];
  endtask

  // interval count is the integer word over the fraction word
  task automatic set_expected(input int idx);
    exp_n = {vec_timing[idx].prf_int, vec_timing[idx].prf_frac};
    exp_m = vec_timing[idx].adc_time;
  endtask

  task automatic wait_for_init;
    @(posedge aclk);
    #2;
    while (!chirp_init) begin
      @(posedge aclk);
      #2;
    end
  endtask

  // chirp generator, busy for K plus jitter, then done, then a ready gap
  task automatic run_chirp(input int k, input int g);
    int len;
    len = k + ($unsigned($random(seed)) % 4);
    chirp_active = 1'b1;
    repeat (len) begin
      @(posedge aclk);
      #2;
    end
    chirp_active = 1'b0;
    chirp_done = 1'b1;
    @(posedge aclk);
    #2;
    chirp_done = 1'b0;
    if (g > 0) begin
      chirp_ready = 1'b0;
      repeat (g) begin
        @(posedge aclk);
        #2;
      end
      chirp_ready = 1'b1;
    end
  endtask

  task automatic finish_run;
    $display("errors: %0d value mismatches, %0d other", mismatch_count, other_errors);
    if (mismatch_count + other_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  initial begin
    aresetn = 1'b0;
    timing_in = '0;
    chirp_params_in = '0;
    chirp_ready = 1'b0;
    chirp_active = 1'b0;
    chirp_done = 1'b0;
    exp_n = '0;
    exp_m = '0;
    load_vectors(ok);
    if (!ok) begin
      finish_run();
    end else begin
      apply_vector(0);
      set_expected(0);
      repeat (4) @(posedge aclk);
      #2;
      aresetn = 1'b1;
      // first timing words through the resync chain before ready
      repeat (6) @(posedge aclk);
      #2;
      chirp_ready = 1'b1;
      for (v = 0; v < n_vec; v = v + 1) begin
        wait_for_init();
        set_expected(v);
        // next timing lands well before the sequencer is back in idle
        if (v + 1 < n_vec) apply_vector(v + 1);
        run_chirp(vec_k[v], vec_g[v]);
      end
      // one more pulse so the last gap is timed
      wait_for_init();
      repeat (4) @(posedge aclk);
      finish_run();
    end
  end

  // watchdog
  initial begin
    wait (limit_set);
    while (cycle_cnt < cycle_limit) begin
      @(posedge aclk);
      cycle_cnt = cycle_cnt + 1;
    end
    $display("error: run did not finish within %0d clock cycles", cycle_limit);
    other_errors = other_errors + 1;
    finish_run();
  end

endmodule
